// ==== vlog.f ====
hw/fm_op_pkg.sv
hw/fm_reg_pkg.sv
hw/op_state_ram.sv
hw/quarter_sine_rom.sv
hw/fm_reg_decode.sv
hw/operator_exec.sv
hw/sample_mixer.sv
hw/fm_operator_core.sv
verification/fm_operator_core_tb.sv

// ==== Bender.yml ====
package:
  name: fm_operator_core

sources:
  - hw/fm_op_pkg.sv
  - hw/fm_reg_pkg.sv
  - hw/op_state_ram.sv
  - hw/quarter_sine_rom.sv
  - hw/fm_reg_decode.sv
  - hw/operator_exec.sv
  - hw/sample_mixer.sv
  - hw/fm_operator_core.sv
  - target: test
    files:
      - verification/fm_operator_core_tb.sv

// ==== verification/fm_operator_core_tb.sv ====
// FM operator core testbench
module fm_operator_core_tb
    import fm_op_pkg::*;
    import fm_reg_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int  NUM_OPS = 8;
    localparam int  TIMEOUT = 100;   // Cycles allowed for one scan
    localparam real PI      = 3.14159265358979323846;

    logic                      clk = 1'b0;
    logic                      arst_n;
    logic                      reg_wr;
    logic [REG_ADDR_WIDTH-1:0] reg_addr;
    logic [REG_DATA_WIDTH-1:0] reg_data;
    logic                      sample_en;
    logic                      sample_valid;
    logic signed [15:0]        sample_out;

    // Reference model of every operator
    logic [19:0] phase_m [NUM_OPS];
    logic [15:0] inc_m   [NUM_OPS];
    waveform_t   wave_m  [NUM_OPS];
    logic [3:0]  atten_m [NUM_OPS];
    bit          key_m   [NUM_OPS];
    int          sine_tab [256];
    logic [31:0] rng = 32'h71ee_1232;
    int          errors = 0;
    int          checks = 0;

    fm_operator_core #(.NUM_OPS(NUM_OPS)) DUT (
        .clk, .arst_n, .reg_wr, .reg_addr, .reg_data, .sample_en, .sample_valid, .sample_out
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Output of one operator at its freshly updated phase
    function automatic int op_output(input logic [19:0] ph, input waveform_t w,
                                     input logic [3:0] at);
        logic [7:0] idx;
        int         mag;
        idx = ph[18] ? ~ph[17:10] : ph[17:10];   // Second and fourth quadrant read backwards
        mag = sine_tab[idx] >> at;
        case (w)
            WAVE_SINE: return ph[19] ? -mag : mag;
            WAVE_HALF: return ph[19] ? 0 : mag;
            WAVE_ABS:  return mag;
            default:   return ph[18] ? 0 : mag;
        endcase
    endfunction

    // Advances the model by one scan and returns the summed sample
    function automatic int predict_sample();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_OPS; i++) begin
            phase_m[i] = key_m[i] ? 20'd0 : phase_m[i] + 20'(inc_m[i]);
            key_m[i]   = 1'b0;
            sum += op_output(phase_m[i], wave_m[i], atten_m[i]);
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // One register write followed by an idle cycle
    task automatic write_reg(input logic [1:0] field, input int op, input logic [15:0] data);
        reg_wr   = 1'b1;
        reg_addr = {field, 6'(op)};
        reg_data = data;
        @(posedge clk);
        #1 reg_wr = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic write_phase_inc(input int op, input logic [15:0] inc);
        write_reg(FIELD_PHASE_INC, op, inc);
        inc_m[op] = inc;
    endtask

    task automatic write_shape(input int op, input waveform_t w, input logic [3:0] at);
        write_reg(FIELD_SHAPE, op, 16'({at, w}));
        wave_m[op]  = w;
        atten_m[op] = at;
    endtask

    task automatic write_key_on(input int op);
        write_reg(FIELD_KEY_ON, op, 16'h0);
        key_m[op] = 1'b1;
    endtask

    // Strobes sample_en and checks the sample against the model
    task automatic run_sample(input string name, output int latency);
        int expected;
        int cnt;
        expected  = predict_sample();
        sample_en = 1'b1;
        @(posedge clk);
        #1 sample_en = 1'b0;
        cnt = 0;
        while (!sample_valid && cnt < TIMEOUT) begin
            @(posedge clk);
            #1 cnt++;
        end
        latency = cnt;
        checks++;
        assert (sample_valid) else begin
            $display("%s: sample_valid did not arrive within %0d cycles", name, TIMEOUT);
            errors++;
        end
        if (sample_valid) begin
            check_value(name, expected, int'(sample_out));
        end
    endtask

    task automatic run_samples(input string name, input int count);
        int lat;
        for (int n = 0; n < count; n++) begin
            run_sample(name, lat);
        end
    endtask

    // Idle operators sit at phase zero, which reads the first table entry
    task automatic test_reset_silence();
        int lat;
        run_sample("test_reset_silence", lat);
        check_value("test_reset_silence latency", NUM_OPS + 4, lat);
    endtask

    task automatic test_phase_accumulation();
        for (int i = 1; i < NUM_OPS; i++) begin
            write_shape(i, WAVE_SINE, 4'd15);   // Full attenuation silences them
        end
        rng = xorshift32(rng);
        write_phase_inc(0, rng[15:0] | 16'h8000);   // Top bit set so the phase wraps early
        write_shape(0, WAVE_SINE, 4'd0);
        run_samples("test_phase_accumulation", 40);
    endtask

    task automatic test_waveforms();
        write_phase_inc(0, 16'h4003);   // About 64 samples per period
        for (int w = 0; w < 4; w++) begin
            write_shape(0, waveform_t'(w), 4'd0);
            run_samples("test_waveforms", 66);
        end
    endtask

    task automatic test_attenuation_mix();
        for (int i = 0; i < NUM_OPS; i++) begin
            rng = xorshift32(rng);
            write_phase_inc(i, rng[15:0]);
            write_shape(i, waveform_t'(rng[17:16]), rng[21:18]);
        end
        run_samples("test_attenuation_mix", 20);
    endtask

    task automatic test_key_on_reset();
        write_shape(3, WAVE_SINE, 4'd0);   // Audible, so the restart shows in the sum
        write_key_on(3);
        run_samples("test_key_on_reset", 4);
        write_shape(0, WAVE_SINE, 4'd0);
        write_shape(6, WAVE_SINE, 4'd0);
        write_key_on(0);
        write_key_on(6);
        run_samples("test_key_on_reset", 4);
    endtask

    task automatic test_register_field_isolation();
        write_shape(2, WAVE_ABS, 4'd1);
        write_reg(2'd3, 2, 16'hffff);   // Reserved field code
        write_reg(2'd3, 5, 16'h0000);
        run_samples("test_register_field_isolation", 8);
    endtask

    initial begin
        arst_n    = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_data  = '0;
        sample_en = 1'b0;
        for (int i = 0; i < 256; i++) begin
            sine_tab[i] = $rtoi(4095.0 * $sin((real'(i) + 0.5) * PI / 512.0) + 0.5);
        end
        for (int i = 0; i < NUM_OPS; i++) begin
            phase_m[i] = '0;
            inc_m[i]   = '0;
            wave_m[i]  = WAVE_SINE;
            atten_m[i] = '0;
            key_m[i]   = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        test_reset_silence();
        test_phase_accumulation();
        test_waveforms();
        test_attenuation_mix();
        test_key_on_reset();
        test_register_field_isolation();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/fm_operator_core.sv ====
// FM operator subsystem
module fm_operator_core
    import fm_op_pkg::*;
    import fm_reg_pkg::*;
#(
    parameter int  NUM_OPS = 8,
    localparam int IDX_W   = $clog2(NUM_OPS),
    localparam int SUM_W   = OP_OUT_WIDTH + $clog2(NUM_OPS)
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      reg_wr,
    input  logic [REG_ADDR_WIDTH-1:0] reg_addr,
    input  logic [REG_DATA_WIDTH-1:0] reg_data,
    input  logic                      sample_en,
    output logic                      sample_valid,
    output logic signed [SUM_W-1:0]   sample_out
);

    logic                           op_valid;
    logic [IDX_W-1:0]               op_idx;
    logic                           op_last;
    logic                           key_on;
    logic [PHASE_INC_WIDTH-1:0]     phase_inc;
    waveform_t                      waveform;
    logic [ATTEN_WIDTH-1:0]         atten;
    logic                           op_out_valid;
    logic signed [OP_OUT_WIDTH-1:0] op_out;
    logic                           op_out_last;

    fm_reg_decode #(
        .NUM_OPS (NUM_OPS)
    ) u_decode (
        .clk, .arst_n, .reg_wr, .reg_addr, .reg_data, .sample_en,
        .op_valid, .op_idx, .op_last, .key_on, .phase_inc, .waveform, .atten
    );

    // Three cycles from op_valid to op_out_valid
    operator_exec #(
        .NUM_OPS (NUM_OPS)
    ) u_exec (
        .clk, .arst_n, .op_valid, .op_idx, .op_last, .key_on, .phase_inc, .waveform,
        .atten, .op_out_valid, .op_out, .op_out_last
    );

    sample_mixer #(
        .NUM_OPS (NUM_OPS)
    ) u_mixer (
        .clk, .arst_n, .op_out_valid, .op_out, .op_out_last, .sample_valid, .sample_out
    );

endmodule

// ==== hw/sample_mixer.sv ====
// Operator output mixer
module sample_mixer
    import fm_op_pkg::*;
#(
    parameter int  NUM_OPS = 8,
    localparam int SUM_W   = OP_OUT_WIDTH + $clog2(NUM_OPS)
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           op_out_valid,
    input  logic signed [OP_OUT_WIDTH-1:0] op_out,
    input  logic                           op_out_last,
    output logic                           sample_valid,
    output logic signed [SUM_W-1:0]        sample_out
);

    logic signed [SUM_W-1:0] acc;
    logic signed [SUM_W-1:0] acc_next;

    assign acc_next = acc + SUM_W'(op_out);   // Sign-extended operator output

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc          <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= op_out_valid && op_out_last;
            if (op_out_valid) begin
                acc <= op_out_last ? '0 : acc_next;   // Next scan starts from silence
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_out_valid && op_out_last) begin
            sample_out <= acc_next;
        end
    end

    // Scans are at least NUM_OPS cycles apart, so samples never come back to back
    a_single_cycle_valid: assert property (@(posedge clk) disable iff (!arst_n)
        sample_valid |=> !sample_valid);

endmodule

// ==== hw/operator_exec.sv ====
// Phase and waveform pipeline
module operator_exec
    import fm_op_pkg::*;
#(
    parameter int  NUM_OPS = 8,
    localparam int IDX_W   = $clog2(NUM_OPS)
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           op_valid,
    input  logic [IDX_W-1:0]               op_idx,
    input  logic                           op_last,
    input  logic                           key_on,
    input  logic [PHASE_INC_WIDTH-1:0]     phase_inc,
    input  waveform_t                      waveform,
    input  logic [ATTEN_WIDTH-1:0]         atten,
    output logic                           op_out_valid,
    output logic signed [OP_OUT_WIDTH-1:0] op_out,
    output logic                           op_out_last
);

    localparam int IDX_LSB = PHASE_WIDTH - 2 - SINE_IDX_WIDTH;

    typedef logic [PHASE_WIDTH-1:0] phase_t;

    logic                           s1_valid;
    logic                           s1_last;
    logic                           s1_key_on;
    logic [IDX_W-1:0]               s1_idx;
    logic [PHASE_INC_WIDTH-1:0]     s1_inc;
    waveform_t                      s1_wave;
    logic [ATTEN_WIDTH-1:0]         s1_atten;
    phase_t                         old_phase;
    phase_t                         new_phase;
    logic [SINE_IDX_WIDTH-1:0]      sine_idx;
    logic                           s2_valid;
    logic                           s2_last;
    waveform_t                      s2_wave;
    logic [ATTEN_WIDTH-1:0]         s2_atten;
    logic [1:0]                     s2_quad;   // Phase bits 19 and 18
    logic [SINE_AMP_WIDTH-1:0]      amp;
    logic [SINE_AMP_WIDTH-1:0]      mag;
    logic signed [OP_OUT_WIDTH-1:0] mag_s;
    logic signed [OP_OUT_WIDTH-1:0] wave_out;

    // Stage 1 reads the stored phase, stage 2 writes the updated one back
    op_state_ram #(
        .DEPTH (NUM_OPS),
        .T     (phase_t)
    ) phase_ram (
        .clk,
        .arst_n,
        .we    (s1_valid),
        .waddr (s1_idx),
        .wdata (new_phase),
        .raddr (op_idx),
        .rdata (old_phase)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid     <= 1'b0;
            s1_last      <= 1'b0;
            s1_key_on    <= 1'b0;
            s2_valid     <= 1'b0;
            s2_last      <= 1'b0;
            op_out_valid <= 1'b0;
            op_out_last  <= 1'b0;
        end else begin
            s1_valid     <= op_valid;
            s1_last      <= op_valid && op_last;
            s1_key_on    <= op_valid && key_on;
            s2_valid     <= s1_valid;
            s2_last      <= s1_last;
            op_out_valid <= s2_valid;
            op_out_last  <= s2_valid && s2_last;
        end
    end

    // Accumulator wraps modulo 2**20
    assign new_phase = s1_key_on ? '0 : old_phase + PHASE_WIDTH'(s1_inc);

    // Fold the second and fourth quadrant back onto the quarter table
    assign sine_idx = new_phase[PHASE_WIDTH-2] ? ~new_phase[IDX_LSB +: SINE_IDX_WIDTH]
                                               : new_phase[IDX_LSB +: SINE_IDX_WIDTH];

    quarter_sine_rom sine_rom (
        .clk,
        .idx (sine_idx),
        .amp (amp)
    );

    always_ff @(posedge clk) begin
        s1_idx   <= op_idx;
        s1_inc   <= phase_inc;
        s1_wave  <= waveform;
        s1_atten <= atten;
        s2_wave  <= s1_wave;
        s2_atten <= s1_atten;
        s2_quad  <= new_phase[PHASE_WIDTH-1 -: 2];
    end

    assign mag   = amp >> s2_atten;
    assign mag_s = signed'(OP_OUT_WIDTH'(mag));

    always_comb begin
        unique case (s2_wave)
            WAVE_SINE:    wave_out = s2_quad[1] ? -mag_s : mag_s;
            WAVE_HALF:    wave_out = s2_quad[1] ? '0 : mag_s;
            WAVE_ABS:     wave_out = mag_s;
            WAVE_QUARTER: wave_out = s2_quad[0] ? '0 : mag_s;
        endcase
    end

    always_ff @(posedge clk) begin
        op_out <= wave_out;
    end

endmodule

// ==== hw/fm_reg_decode.sv ====
// Operator register file and scan sequencer
module fm_reg_decode
    import fm_op_pkg::*;
    import fm_reg_pkg::*;
#(
    parameter int  NUM_OPS = 8,
    localparam int IDX_W   = $clog2(NUM_OPS)
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       reg_wr,
    input  logic [REG_ADDR_WIDTH-1:0]  reg_addr,
    input  logic [REG_DATA_WIDTH-1:0]  reg_data,
    input  logic                       sample_en,
    output logic                       op_valid,
    output logic [IDX_W-1:0]           op_idx,
    output logic                       op_last,
    output logic                       key_on,
    output logic [PHASE_INC_WIDTH-1:0] phase_inc,
    output waveform_t                  waveform,
    output logic [ATTEN_WIDTH-1:0]     atten
);

    localparam logic [IDX_W-1:0] LAST_OP = IDX_W'(NUM_OPS - 1);

    reg_field_t              wr_field;
    logic [REG_OP_WIDTH-1:0] wr_op;
    logic                    wr_in_range;
    logic                    cfg_wr;
    logic                    kon_wr;
    logic                    scan_active;
    logic [IDX_W-1:0]        scan_cnt;
    logic [NUM_OPS-1:0]      pending;   // Key-on requests not yet issued
    logic [IDX_W-1:0]        raddr;
    op_cfg_t                 rd_cfg;
    logic                    rmw_q;     // Second half of a field write
    logic                    fwd_q;
    logic [IDX_W-1:0]        rmw_op;
    logic                    rmw_shape;
    logic [REG_DATA_WIDTH-1:0] rmw_data;
    op_cfg_t                 last_cfg;
    op_cfg_t                 old_cfg;
    op_cfg_t                 new_cfg;

    assign wr_field    = reg_field_t'(reg_addr[REG_ADDR_WIDTH-1 -: REG_FIELD_WIDTH]);
    assign wr_op       = reg_addr[REG_OP_WIDTH-1:0];
    assign wr_in_range = (wr_op < NUM_OPS);
    assign cfg_wr = reg_wr && wr_in_range &&
                    (wr_field == FIELD_PHASE_INC || wr_field == FIELD_SHAPE);
    assign kon_wr = reg_wr && wr_in_range && (wr_field == FIELD_KEY_ON);

    // The read port serves the scan, and field writes between scans
    assign raddr = scan_active ? scan_cnt : wr_op[IDX_W-1:0];

    op_state_ram #(
        .DEPTH (NUM_OPS),
        .T     (op_cfg_t)
    ) cfg_ram (
        .clk,
        .arst_n,
        .we    (rmw_q),
        .waddr (rmw_op),
        .wdata (new_cfg),
        .raddr (raddr),
        .rdata (rd_cfg)
    );

    // A write right behind another one to the same operator takes the value just written
    always_comb begin
        old_cfg = fwd_q ? last_cfg : rd_cfg;
        new_cfg = old_cfg;
        if (rmw_shape) begin
            new_cfg.waveform = waveform_t'(rmw_data[SHAPE_WAVE_LSB +: $bits(waveform_t)]);
            new_cfg.atten    = rmw_data[SHAPE_ATTEN_LSB +: ATTEN_WIDTH];
        end else begin
            new_cfg.phase_inc = rmw_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rmw_q <= 1'b0;
            fwd_q <= 1'b0;
        end else begin
            rmw_q <= cfg_wr && !scan_active;
            fwd_q <= rmw_q && (rmw_op == wr_op[IDX_W-1:0]);
        end
    end

    always_ff @(posedge clk) begin
        rmw_op    <= wr_op[IDX_W-1:0];
        rmw_shape <= (wr_field == FIELD_SHAPE);
        rmw_data  <= reg_data;
        if (rmw_q) begin
            last_cfg <= new_cfg;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_active <= 1'b0;
            scan_cnt    <= '0;
        end else if (scan_active) begin
            scan_active <= (scan_cnt != LAST_OP);
            scan_cnt    <= (scan_cnt == LAST_OP) ? '0 : scan_cnt + 1'b1;
        end else if (sample_en) begin
            scan_active <= 1'b1;   // Operator 0 goes out on the next edge
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            if (scan_active) begin
                pending[scan_cnt] <= 1'b0;
            end
            if (kon_wr) begin
                pending[wr_op[IDX_W-1:0]] <= 1'b1;   // A new request beats the clear
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_valid <= 1'b0;
            op_idx   <= '0;
            op_last  <= 1'b0;
            key_on   <= 1'b0;
        end else begin
            op_valid <= scan_active;
            op_idx   <= scan_cnt;
            op_last  <= scan_active && (scan_cnt == LAST_OP);
            key_on   <= scan_active && pending[scan_cnt];
        end
    end

    assign phase_inc = rd_cfg.phase_inc;   // Config arrives from the RAM with op_valid
    assign waveform  = rd_cfg.waveform;
    assign atten     = rd_cfg.atten;

    a_no_overlapping_scan: assert property (@(posedge clk) disable iff (!arst_n)
        sample_en |-> !scan_active);

    a_op_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        reg_wr |-> wr_in_range);

    // Field writes need the read port, which the scan holds while it runs
    a_cfg_wr_idle: assert property (@(posedge clk) disable iff (!arst_n)
        cfg_wr |-> !scan_active);

endmodule

// ==== hw/quarter_sine_rom.sv ====
// Quarter-period sine table
module quarter_sine_rom
    import fm_op_pkg::*;
(
    input  logic                      clk,
    input  logic [SINE_IDX_WIDTH-1:0] idx,
    output logic [SINE_AMP_WIDTH-1:0] amp
);

    localparam int  DEPTH      = 2 ** SINE_IDX_WIDTH;
    localparam real PI         = 3.14159265358979323846;
    localparam real FULL_SCALE = real'((2 ** SINE_AMP_WIDTH) - 1);

    typedef logic [SINE_AMP_WIDTH-1:0] table_t [DEPTH];

    // Entries sit half a step off the quadrant edges, so the folded table is symmetric
    function automatic table_t build_table();
        table_t t;
        real    angle;
        for (int i = 0; i < DEPTH; i++) begin
            angle = (real'(i) + 0.5) * PI / real'(2 * DEPTH);
            t[i]  = SINE_AMP_WIDTH'($rtoi(FULL_SCALE * $sin(angle) + 0.5));
        end
        return t;
    endfunction

    localparam table_t SINE_TABLE = build_table();

    always_ff @(posedge clk) begin
        amp <= SINE_TABLE[idx];
    end

endmodule

// ==== hw/op_state_ram.sv ====
// Per-operator state memory
module op_state_ram #(
    parameter int  DEPTH = 8,
    parameter type T     = logic [7:0],
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  T              wdata,
    input  logic [AW-1:0] raddr,
    output T              rdata
);

    T mem [DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem <= '{default: '0};
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // One cycle of read latency, a same-address write shows up on the next read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else begin
            rdata <= mem[raddr];
        end
    end

    // The caller must keep its operator index inside the array
    a_waddr_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        we |-> (int'(waddr) < DEPTH));

endmodule

// ==== hw/fm_reg_pkg.sv ====
// Register map definitions
package fm_reg_pkg;

    localparam int REG_ADDR_WIDTH  = 8;
    localparam int REG_DATA_WIDTH  = 16;

    // Address bits 7 to 6 select the field, bits 5 to 0 the operator
    localparam int REG_FIELD_WIDTH = 2;
    localparam int REG_OP_WIDTH    = REG_ADDR_WIDTH - REG_FIELD_WIDTH;

    // Bit positions inside the data word of a shape write
    localparam int SHAPE_WAVE_LSB  = 0;
    localparam int SHAPE_ATTEN_LSB = 2;

    // Code 3 is reserved and writes to it are dropped
    typedef enum logic [REG_FIELD_WIDTH-1:0] {
        FIELD_PHASE_INC = 2'd0,
        FIELD_SHAPE     = 2'd1,
        FIELD_KEY_ON    = 2'd2  // Data ignored, requests a phase reset
    } reg_field_t;

endpackage

// ==== hw/fm_op_pkg.sv ====
// Operator datapath definitions
package fm_op_pkg;

    localparam int PHASE_WIDTH     = 20; // One full period per accumulator wrap
    localparam int PHASE_INC_WIDTH = 16; // Zero-extended into the accumulator
    localparam int SINE_IDX_WIDTH  = 8;  // Taken from phase bits 17 to 10
    localparam int SINE_AMP_WIDTH  = 12;
    localparam int OP_OUT_WIDTH    = 13; // Table amplitude plus sign
    localparam int ATTEN_WIDTH     = 4;  // Right shift applied to the amplitude

    typedef enum logic [1:0] {
        WAVE_SINE    = 2'd0,
        WAVE_HALF    = 2'd1, // Negative half muted
        WAVE_ABS     = 2'd2, // Rectified sine
        WAVE_QUARTER = 2'd3  // Rectified, muted in every second quarter
    } waveform_t;

    // Static settings of one operator
    typedef struct packed {
        logic [PHASE_INC_WIDTH-1:0] phase_inc;
        waveform_t                  waveform;
        logic [ATTEN_WIDTH-1:0]     atten;
    } op_cfg_t;

endpackage
